//--- logic/fp_pkg.sv
/*
 * FP operand front end package.
 * Register map, FCLASS bit positions, exponent recoding constants
 * and the two-way decode of the 64-bit operand word.
 */
package fp_pkg;

    localparam int RESULT_W = 65;
    localparam int CLASS_W  = 10;

    // Byte addresses of the register map.
    localparam logic [4:0] ADDR_DATA_LO  = 5'h00;
    localparam logic [4:0] ADDR_DATA_HI  = 5'h04;
    localparam logic [4:0] ADDR_FMT      = 5'h08;
    localparam logic [4:0] ADDR_RES_LO   = 5'h0C;
    localparam logic [4:0] ADDR_RES_HI   = 5'h10;
    localparam logic [4:0] ADDR_RES_SIGN = 5'h14;
    localparam logic [4:0] ADDR_CLASS    = 5'h18;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    // FCLASS bit positions.
    localparam int CLS_NEG_INF  = 0;
    localparam int CLS_NEG_NORM = 1;
    localparam int CLS_NEG_SUB  = 2;
    localparam int CLS_NEG_ZERO = 3;
    localparam int CLS_POS_ZERO = 4;
    localparam int CLS_POS_SUB  = 5;
    localparam int CLS_POS_NORM = 6;
    localparam int CLS_POS_INF  = 7;
    localparam int CLS_SNAN     = 8;
    localparam int CLS_QNAN     = 9;

    // Internal exponent is biased by 2047.
    localparam logic [11:0] EXP_SP_OFFSET   = 12'h780;
    localparam logic [11:0] EXP_DP_OFFSET   = 12'h400;
    localparam logic [11:0] EXP_SP_SUB_BASE = 12'h781;
    localparam logic [11:0] EXP_DP_SUB_BASE = 12'h401;
    localparam logic [11:0] EXP_SPECIAL     = 12'hFFF;

    typedef struct packed {
        logic [31:0] pad;
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] frac;
    } sp_fields_t;

    typedef struct packed {
        logic        sign;
        logic [10:0] exp;
        logic [51:0] frac;
    } dp_fields_t;

    typedef union packed {
        sp_fields_t sp;
        dp_fields_t dp;
    } fp_word_t;

endpackage

//--- logic/lzc_64.sv
/*
 * 64-bit leading-zero counter.
 * Nibble counters feed a second row of 4-bit counters on the nibble
 * valid flags; a final priority select picks the leading group.
 */
`timescale 1ns/1ps

module lzc_64 (
    input  logic [63:0] data_in,
    output logic [5:0]  lzc,
    output logic        valid
);

    logic [15:0] nib_v;
    logic [1:0]  nib_c [16];
    logic [3:0]  grp_v;
    logic [1:0]  grp_c [4];
    logic [1:0]  top_c;
    logic [1:0]  grp_idx;
    logic [3:0]  nib_idx;

    // Returns {nonzero, leading zero count} of a nibble.
    function automatic logic [2:0] lz4(input logic [3:0] x);
        logic [2:0] r;
        r[2] = |x;
        casez (x)
            4'b1???: r[1:0] = 2'd0;
            4'b01??: r[1:0] = 2'd1;
            4'b001?: r[1:0] = 2'd2;
            default: r[1:0] = 2'd3;
        endcase
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            {nib_v[i], nib_c[i]} = lz4(data_in[4*i +: 4]);
        end
        for (int g = 0; g < 4; g++) begin
            {grp_v[g], grp_c[g]} = lz4(nib_v[4*g +: 4]);
        end
        {valid, top_c} = lz4(grp_v);

        // Count from the top, so index the arrays from the other end.
        grp_idx = 2'd3 - top_c;
        nib_idx = {grp_idx, 2'd3 - grp_c[grp_idx]};

        if (valid) begin
            lzc = {top_c, grp_c[grp_idx], nib_c[nib_idx]};
        end else begin
            lzc = 6'd0;
        end
    end

endmodule

//--- logic/fp_extract.sv
/*
 * FP operand extract.
 * Recodes a single or double operand into sign, 12-bit exponent and
 * 52-bit fraction, normalizing subnormals, and forms the FCLASS vector.
 */
`timescale 1ns/1ps

module fp_extract import fp_pkg::*; (
    input  fp_word_t            data,
    input  logic                fmt,
    output logic [RESULT_W-1:0] result,
    output logic [CLASS_W-1:0]  classification
);

    logic        sign;
    logic        exp_zero;
    logic        exp_ones;
    logic        frac_zero;
    logic [11:0] exp_norm;
    logic [11:0] sub_base;
    logic [11:0] exp_sub;
    logic [51:0] frac_al;
    logic [51:0] frac_sub;
    logic [63:0] probe;
    logic [5:0]  lz_cnt;

    // The probe always ends in ones, so the counter never sees an all-zero word.
    lzc_64 u_lzc_64 (
        .data_in (probe),
        .lzc     (lz_cnt),
        .valid   ()
    );

    // Field select per format; the fraction is left-aligned in 52 bits.
    always_comb begin
        if (fmt) begin
            sign      = data.dp.sign;
            exp_zero  = ~|data.dp.exp;
            exp_ones  = &data.dp.exp;
            frac_zero = ~|data.dp.frac;
            frac_al   = data.dp.frac;
            exp_norm  = {1'b0, data.dp.exp} + EXP_DP_OFFSET;
            sub_base  = EXP_DP_SUB_BASE;
            probe     = {1'b0, data.dp.frac, 11'h7FF};
        end else begin
            sign      = data.sp.sign;
            exp_zero  = ~|data.sp.exp;
            exp_ones  = &data.sp.exp;
            frac_zero = ~|data.sp.frac;
            frac_al   = {data.sp.frac, 29'd0};
            exp_norm  = {4'd0, data.sp.exp} + EXP_SP_OFFSET;
            sub_base  = EXP_SP_SUB_BASE;
            probe     = {1'b0, data.sp.frac, 40'hFF_FFFF_FFFF};
        end
    end

    // Leading zero count of the probe already includes the hidden bit.
    assign frac_sub = frac_al << lz_cnt;
    assign exp_sub  = sub_base - {6'd0, lz_cnt};

    always_comb begin
        result = {sign, 64'd0};
        if (exp_ones) begin
            result[63:0] = {EXP_SPECIAL, frac_al};
        end else if (!exp_zero) begin
            result[63:0] = {exp_norm, frac_al};
        end else if (!frac_zero) begin
            result[63:0] = {exp_sub, frac_sub};
        end
    end

    always_comb begin
        classification = '0;
        if (exp_ones) begin
            if (frac_zero) begin
                classification[sign ? CLS_NEG_INF : CLS_POS_INF] = 1'b1;
            end else if (result[51]) begin
                classification[CLS_QNAN] = 1'b1;
            end else begin
                classification[CLS_SNAN] = 1'b1;
            end
        end else if (exp_zero) begin
            if (frac_zero) begin
                classification[sign ? CLS_NEG_ZERO : CLS_POS_ZERO] = 1'b1;
            end else begin
                classification[sign ? CLS_NEG_SUB : CLS_POS_SUB] = 1'b1;
            end
        end else begin
            classification[sign ? CLS_NEG_NORM : CLS_POS_NORM] = 1'b1;
        end
    end

endmodule

//--- logic/fp_axil_regs.sv
/*
 * AXI4-Lite register block for the FP front end.
 * Holds the operand and format registers, samples the extract output
 * every cycle and serves single-outstanding reads and writes.
 */
`timescale 1ns/1ps

module fp_axil_regs import fp_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,

    input  logic [4:0]          awaddr,
    input  logic                awvalid,
    output logic                awready,

    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,

    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,

    input  logic [4:0]          araddr,
    input  logic                arvalid,
    output logic                arready,

    output logic [31:0]         rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,

    output fp_word_t            op_data,
    output logic                op_fmt,
    input  logic [RESULT_W-1:0] ext_result,
    input  logic [CLASS_W-1:0]  ext_class
);

    logic                wr_accept;
    logic                wr_pend;
    logic                wr_ok;
    logic                rd_accept;
    logic                rd_ok;
    logic [31:0]         rd_mux;
    logic [RESULT_W-1:0] res_q;
    logic [CLASS_W-1:0]  class_q;

    // A write stays pending one extra cycle so bvalid lines up with the result register.
    assign wr_accept = awvalid & wvalid & ~wr_pend & ~bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    assign rd_accept = arvalid & ~rvalid;
    assign arready   = rd_accept;

    // Every write is a full-word write and ignores wstrb.
    assign wr_ok = (awaddr == ADDR_DATA_LO) || (awaddr == ADDR_DATA_HI) ||
                   (awaddr == ADDR_FMT);

    always_comb begin
        rd_ok  = 1'b1;
        rd_mux = '0;
        case (araddr)
            ADDR_DATA_LO:  rd_mux = op_data[31:0];
            ADDR_DATA_HI:  rd_mux = op_data[63:32];
            ADDR_FMT:      rd_mux = {31'd0, op_fmt};
            ADDR_RES_LO:   rd_mux = res_q[31:0];
            ADDR_RES_HI:   rd_mux = res_q[63:32];
            ADDR_RES_SIGN: rd_mux = {31'd0, res_q[64]};
            ADDR_CLASS:    rd_mux = {{(32 - CLASS_W){1'b0}}, class_q};
            default:       rd_ok  = 1'b0;
        endcase
    end

    // Operand registers.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_data <= '0;
            op_fmt  <= 1'b0;
        end else if (wr_accept) begin
            case (awaddr)
                ADDR_DATA_LO: op_data[31:0]  <= wdata;
                ADDR_DATA_HI: op_data[63:32] <= wdata;
                ADDR_FMT:     op_fmt         <= wdata[0];
                default:      ;
            endcase
        end
    end

    // Registered copy of the extract output.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_q   <= '0;
            class_q <= CLASS_W'(1) << CLS_POS_ZERO;
        end else begin
            res_q   <= ext_result;
            class_q <= ext_class;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_pend <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            wr_pend <= wr_accept;
            if (wr_pend) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end
    end

    // Response payload.
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_accept) begin
            rdata <= rd_mux;
            rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

//--- logic/fp_front_top.sv
/*
 * FP operand front end top level.
 * Connects the AXI4-Lite register block to the operand extract.
 */
`timescale 1ns/1ps

module fp_front_top import fp_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  logic [4:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,

    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,

    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,

    input  logic [4:0]  araddr,
    input  logic        arvalid,
    output logic        arready,

    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    fp_word_t            op_data;
    logic                op_fmt;
    logic [RESULT_W-1:0] ext_result;
    logic [CLASS_W-1:0]  ext_class;

    fp_axil_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .op_data    (op_data),
        .op_fmt     (op_fmt),
        .ext_result (ext_result),
        .ext_class  (ext_class)
    );

    fp_extract u_extract (
        .data           (op_data),
        .fmt            (op_fmt),
        .result         (ext_result),
        .classification (ext_class)
    );

endmodule

//--- test/fp_front_tb.sv
/*
 * Testbench for the FP operand front end.
 * Drives operand vectors from a data file over AXI4-Lite and checks the
 * recoded result, the class vector, register readback and error responses.
 */
`timescale 1ns/1ps

module fp_front_tb import fp_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic [4:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [4:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    logic [31:0] vec_fmt [$];
    logic [63:0] vec_op  [$];
    logic [64:0] vec_res [$];
    logic [9:0]  vec_cls [$];

    int error_count  = 0;
    int test_count   = 0;
    int failed_tests = 0;
    int cycle_count  = 0;
    int cycle_limit  = 0;

    fp_front_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Ends the run if the tests take longer than the vector count allows.
    initial begin
        while (cycle_limit == 0 || cycle_count <= cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
        $display("Done: errors found");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s actual %h expected %h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        test_count++;
        if (error_count == errors_at_start) begin
            $display("PASS  %s", name);
        end else begin
            failed_tests++;
            $display("FAIL  %s (%0d errors)", name, error_count - errors_at_start);
        end
    endtask

    // Called and returns on a rising edge.
    task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int delay;
        delay = $urandom % 4;
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hF;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!(awready && wready)) begin
            @(negedge clk);
        end
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clk);
        while (!bvalid) begin
            @(negedge clk);
        end
        resp = bresp;
        repeat (delay) @(posedge clk);
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [4:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int delay;
        delay = $urandom % 4;
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) begin
            @(negedge clk);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        while (!rvalid) begin
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        repeat (delay) @(posedge clk);
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic write_expect(input logic [4:0] addr, input logic [31:0] data,
                                input logic [1:0] expected_resp);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check_value($sformatf("bresp addr %h", addr), 32'(resp), 32'(expected_resp));
    endtask

    task automatic read_expect(input logic [4:0] addr, input string name,
                               input logic [31:0] expected, input logic [1:0] expected_resp);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        check_value(name, data, expected);
        check_value({name, " rresp"}, 32'(resp), 32'(expected_resp));
    endtask

    task automatic load_vectors();
        int          fd;
        int          count;
        string       line;
        logic [31:0] fmt_word;
        logic [63:0] op;
        logic [64:0] res;
        logic [9:0]  cls;

        fd = $fopen("test/fp_testdata.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open test/fp_testdata.txt for reading");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            count = $sscanf(line, "%h %h %h %h", fmt_word, op, res, cls);
            if (count != 4) begin
                error_count++;
                $display("Malformed line in test data file: %s", line);
                continue;
            end
            vec_fmt.push_back(fmt_word);
            vec_op.push_back(op);
            vec_res.push_back(res);
            vec_cls.push_back(cls);
        end
        $fclose(fd);
        if (vec_op.size() == 0) begin
            error_count++;
            $display("The test data file holds no vectors");
        end
    endtask

    initial begin
        int errors_at_start;

        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'hfa84));
        rst_n   <= 1'b0;
        awaddr  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        load_vectors();
        cycle_limit = vec_op.size() * 40 + 500;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        errors_at_start = error_count;
        @(negedge clk);
        check_value("bvalid", 32'(bvalid), 32'd0);
        check_value("rvalid", 32'(rvalid), 32'd0);
        @(posedge clk);
        read_expect(ADDR_CLASS, "class", 32'(1) << CLS_POS_ZERO, RESP_OKAY);
        read_expect(ADDR_RES_LO, "res_lo", 32'd0, RESP_OKAY);
        read_expect(ADDR_RES_HI, "res_hi", 32'd0, RESP_OKAY);
        read_expect(ADDR_RES_SIGN, "res_sign", 32'd0, RESP_OKAY);
        finish_test("reset state", errors_at_start);

        for (int i = 0; i < vec_op.size(); i++) begin
            errors_at_start = error_count;
            write_expect(ADDR_DATA_LO, vec_op[i][31:0], RESP_OKAY);
            write_expect(ADDR_DATA_HI, vec_op[i][63:32], RESP_OKAY);
            write_expect(ADDR_FMT, {31'd0, vec_fmt[i][0]}, RESP_OKAY);
            read_expect(ADDR_RES_LO, "res_lo", vec_res[i][31:0], RESP_OKAY);
            read_expect(ADDR_RES_HI, "res_hi", vec_res[i][63:32], RESP_OKAY);
            read_expect(ADDR_RES_SIGN, "res_sign", {31'd0, vec_res[i][64]}, RESP_OKAY);
            read_expect(ADDR_CLASS, "class", {22'd0, vec_cls[i]}, RESP_OKAY);
            finish_test($sformatf("vector %0d %s %h", i, vec_fmt[i][0] ? "dp" : "sp",
                                  vec_op[i]), errors_at_start);
        end

        errors_at_start = error_count;
        write_expect(ADDR_DATA_LO, 32'h1357_9BDF, RESP_OKAY);
        write_expect(ADDR_DATA_HI, 32'h2468_ACE0, RESP_OKAY);
        write_expect(ADDR_FMT, 32'h0000_0001, RESP_OKAY);
        read_expect(ADDR_DATA_LO, "data_lo", 32'h1357_9BDF, RESP_OKAY);
        read_expect(ADDR_DATA_HI, "data_hi", 32'h2468_ACE0, RESP_OKAY);
        read_expect(ADDR_FMT, "fmt", 32'h0000_0001, RESP_OKAY);
        finish_test("register readback", errors_at_start);

        // The operand 0x2468ACE013579BDF stays a double with exponent 0x246 + 0x400.
        errors_at_start = error_count;
        write_expect(ADDR_CLASS, 32'h0000_03FE, RESP_SLVERR);
        write_expect(5'h1C, 32'hFFFF_FFFF, RESP_SLVERR);
        read_expect(ADDR_RES_LO, "res_lo", 32'h1357_9BDF, RESP_OKAY);
        read_expect(ADDR_RES_HI, "res_hi", 32'h6468_ACE0, RESP_OKAY);
        read_expect(ADDR_CLASS, "class", 32'(1) << CLS_POS_NORM, RESP_OKAY);
        read_expect(5'h1C, "unmapped", 32'd0, RESP_SLVERR);
        finish_test("error responses", errors_at_start);

        $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- test/fp_testdata.txt
# fmt operand(64b hex) expected_result(65b hex: sign, exp12, frac52) expected_class(10b hex)
# fmt 0 is single precision in operand bits 31:0, fmt 1 is double precision.
0 000000003F800000 07FF0000000000000 040
0 00000000C0200000 18004000000000000 002
0 DEADBEEF7F7FFFFF 087EFFFFFE0000000 040
0 0000000000800000 07810000000000000 040
0 0000000000400000 07800000000000000 020
0 0000000080000001 176A0000000000000 004
0 0000000000300000 077F8000000000000 020
0 FFFFFFFF000ABCDE 077D579BC00000000 020
0 0000000000000000 00000000000000000 010
0 0000000080000000 10000000000000000 008
0 000000007F800000 0FFF0000000000000 080
0 00000000FF800000 1FFF0000000000000 001
0 000000007FC00000 0FFF8000000000000 200
0 000000007F800001 0FFF0000020000000 100
1 3FF0000000000000 07FF0000000000000 040
1 C008000000000000 18008000000000000 002
1 400921FB54442D18 0800921FB54442D18 040
1 7FEFFFFFFFFFFFFF 0BFEFFFFFFFFFFFFF 040
1 0010000000000000 04010000000000000 040
1 0008000000000000 04000000000000000 020
1 8000000000000001 13CD0000000000000 004
1 0000123456789ABC 03F923456789ABC00 020
1 800FFFFFFFFFFFFF 1400FFFFFFFFFFFFE 004
1 0000000000000000 00000000000000000 010
1 8000000000000000 10000000000000000 008
1 7FF0000000000000 0FFF0000000000000 080
1 FFF0000000000000 1FFF0000000000000 001
1 7FF8000000000000 0FFF8000000000000 200
1 7FF0000000000001 0FFF0000000000001 100
1 FFF8000000000001 1FFF8000000000001 200

//--- fp_front.f
logic/fp_pkg.sv
logic/lzc_64.sv
logic/fp_extract.sv
logic/fp_axil_regs.sv
logic/fp_front_top.sv
test/fp_front_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the FP front end testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module fp_front_tb -Mdir obj_dir -f fp_front.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vfp_front_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
exit 0
